//--- files.f
rtl/exec_pkg.sv
rtl/pipe_stage.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/exec_core.sv
verification/tb_exec_core.sv

//--- rtl/alu_exec.sv
/*
  Combinational execute step.
  Condition test against the flags word, operand b select,
  add/sub/logic/shift/move-immediate result, new flags,
  and the packed result record.
*/
`timescale 1ns/10ps
`default_nettype none

module alu_exec import exec_pkg::*; (
  input  exec_op_t  op,
  input  data_t     a_data,
  input  data_t     b_data,
  input  flags_t    flags,
  output exec_res_t res
);

  logic               cond_ok;
  data_t              imm_ext;
  data_t              b_opnd;
  data_t              b_add;
  logic               is_sub;
  logic               is_arith;
  logic [data_w:0]    sum;
  logic               ovf;
  logic [shamt_w-1:0] shamt;
  data_t              alu_val;
  flags_t             new_flags;

  always_comb begin
    case (op.cond)
      al:      cond_ok = 1'b1;
      nv:      cond_ok = 1'b0;
      eq:      cond_ok = flags.z;
      ne:      cond_ok = !flags.z;
      cs:      cond_ok = flags.c;
      cc:      cond_ok = !flags.c;
      mi:      cond_ok = flags.n;
      pl:      cond_ok = !flags.n;
      vs:      cond_ok = flags.v;
      vc:      cond_ok = !flags.v;
      hi:      cond_ok = flags.c && !flags.z;
      ls:      cond_ok = !flags.c || flags.z;
      ge:      cond_ok = flags.n == flags.v;
      lt:      cond_ok = flags.n != flags.v;
      gt:      cond_ok = !flags.z && (flags.n == flags.v);
      le:      cond_ok = flags.z || (flags.n != flags.v);
      default: cond_ok = 1'b0;
    endcase
  end

  assign imm_ext = {{(data_w-imm_w){op.imm[imm_w-1]}}, op.imm};
  assign b_opnd  = op.use_imm ? imm_ext : b_data;
  assign shamt   = b_opnd[shamt_w-1:0];

  // sub as a + ~b + 1
  assign is_sub   = op.op == op_sub;
  assign is_arith = (op.op == op_add) || is_sub;
  assign b_add    = is_sub ? ~b_opnd : b_opnd;
  assign sum      = {1'b0, a_data} + {1'b0, b_add} + {{data_w{1'b0}}, is_sub};

  // same input signs, different result sign
  assign ovf = (a_data[data_w-1] == b_add[data_w-1]) &&
               (sum[data_w-1] != a_data[data_w-1]);

  always_comb begin
    case (op.op)
      op_add,
      op_sub:  alu_val = sum[data_w-1:0];
      op_and:  alu_val = a_data & b_opnd;
      op_xor:  alu_val = a_data ^ b_opnd;
      op_or:   alu_val = a_data | b_opnd;
      op_shl:  alu_val = a_data << shamt;
      op_shr:  alu_val = a_data >> shamt;
      op_sar:  alu_val = $signed(a_data) >>> shamt;
      op_movi: alu_val = imm_ext;
      default: alu_val = '0;
    endcase
  end

  always_comb begin
    new_flags.c = is_arith ? sum[data_w] : 1'b0;
    new_flags.v = is_arith ? ovf : 1'b0;
    new_flags.n = alu_val[data_w-1];
    new_flags.z = alu_val == '0;
  end

  always_comb begin
    res.executed    = cond_ok;
    res.dest        = op.dest;
    res.write_reg   = cond_ok;
    res.write_flags = cond_ok && op.set_flags;
    res.value       = cond_ok ? alu_val : '0;
    res.flags       = cond_ok ? new_flags : flags;  // skipped keeps old flags
  end

endmodule

`default_nettype wire

//--- rtl/exec_core.sv
/*
  Integer execution lane, top level.
  op_stage -> alu_exec -> res_stage, with reg_file
  committing on the result handshake.
*/
`timescale 1ns/10ps
`default_nettype none

module exec_core import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  exec_op_t  in_op,
  output logic      out_valid,
  input  logic      out_ready,
  output exec_res_t out_res
);

  logic      op_valid;
  logic      op_ready;
  exec_op_t  op_q;
  data_t     a_data;
  data_t     b_data;
  flags_t    cur_flags;
  exec_res_t alu_res;

  pipe_stage #(.payload_t(exec_op_t)) op_stage (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_op),
    .out_valid (op_valid),
    .out_ready (op_ready),
    .out_data  (op_q)
  );

  alu_exec alu_exec (
    .op     (op_q),
    .a_data (a_data),
    .b_data (b_data),
    .flags  (cur_flags),
    .res    (alu_res)
  );

  pipe_stage #(.payload_t(exec_res_t)) res_stage (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (op_valid),
    .in_ready  (op_ready),
    .in_data   (alu_res),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_res)
  );

  // commits on the output handshake
  reg_file reg_file (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (out_valid),
    .commit_ready (out_ready),
    .commit_res   (out_res),
    .rd_a         (op_q.src_a),
    .rd_b         (op_q.src_b),
    .rd_a_data    (a_data),
    .rd_b_data    (b_data),
    .rd_flags     (cur_flags)
  );

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
/*
  Shared definitions for the integer execution lane:
  data, register and immediate widths, condition codes,
  ALU opcodes, flags word, operation and result structs.
*/
`default_nettype none

package exec_pkg;

  localparam int data_w    = 64;
  localparam int reg_count = 16;
  localparam int imm_w     = 16;
  localparam int shamt_w   = 6;  // shift amount bits taken from operand b

  typedef logic [data_w-1:0] data_t;
  typedef logic [3:0]        reg_idx_t;
  typedef logic [imm_w-1:0]  imm_t;  // sign-extended by the alu

  typedef struct packed {
    logic c;  // carry
    logic n;  // sign
    logic v;  // overflow
    logic z;  // zero
  } flags_t;

  typedef enum logic [3:0] {
    al = 4'd0,  nv = 4'd1,
    eq = 4'd2,  ne = 4'd3,
    cs = 4'd4,  cc = 4'd5,
    mi = 4'd6,  pl = 4'd7,
    vs = 4'd8,  vc = 4'd9,
    hi = 4'd10, ls = 4'd11,  // c & !z, and its inverse
    ge = 4'd12, lt = 4'd13,  // n == v, and its inverse
    gt = 4'd14, le = 4'd15   // !z & ge, and its inverse
  } cond_t;

  typedef enum logic [3:0] {
    op_add = 4'd0, op_sub = 4'd1,
    op_and = 4'd2, op_xor = 4'd3, op_or = 4'd4,
    op_shl = 4'd5, op_shr = 4'd6, op_sar = 4'd7,
    op_movi = 4'd8
  } alu_op_t;

  typedef struct packed {
    alu_op_t  op;
    cond_t    cond;
    reg_idx_t src_a;
    reg_idx_t src_b;
    logic     use_imm;    // b from imm instead of src_b
    imm_t     imm;
    reg_idx_t dest;
    logic     set_flags;
  } exec_op_t;

  // flags: add/sub take c, v, n, z from the 65 bit sum, sub = a + ~b + 1
  // every other op clears c and v, n and z from the value
  // a skipped op carries value zero and the old flags
  typedef struct packed {
    logic     executed;     // condition held
    reg_idx_t dest;
    logic     write_reg;    // every executed op writes dest
    logic     write_flags;  // executed & set_flags
    data_t    value;
    flags_t   flags;
  } exec_res_t;

endpackage

`default_nettype wire

//--- rtl/pipe_stage.sv
/*
  Valid/ready register slice, one entry, full throughput.
  Payload type is a parameter.
*/
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic load;

  // empty, or the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) out_data <= in_data;  // payload, no reset
  end

  // stalled output must hold
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
/*
  Architectural register file and flags word.
  Commit on the result handshake, reads bypass the
  value and flags committing in the same cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module reg_file import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      commit_valid,
  input  logic      commit_ready,
  input  exec_res_t commit_res,
  input  reg_idx_t  rd_a,
  input  reg_idx_t  rd_b,
  output data_t     rd_a_data,
  output data_t     rd_b_data,
  output flags_t    rd_flags
);

  data_t  regs [reg_count];
  flags_t flags_q;
  logic   commit;
  logic   wr_reg;
  logic   wr_flags;

  assign commit   = commit_valid && commit_ready;
  assign wr_reg   = commit && commit_res.write_reg;
  assign wr_flags = commit && commit_res.write_flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) regs[i] <= '0;
      flags_q <= '0;
    end else begin
      if (wr_reg) regs[commit_res.dest] <= commit_res.value;
      if (wr_flags) flags_q <= commit_res.flags;
    end
  end

  // forward the committing result
  assign rd_a_data = (wr_reg && commit_res.dest == rd_a) ? commit_res.value : regs[rd_a];
  assign rd_b_data = (wr_reg && commit_res.dest == rd_b) ? commit_res.value : regs[rd_b];
  assign rd_flags  = wr_flags ? commit_res.flags : flags_q;

  // flags move only on a flag-writing transfer
  a_flags_commit: assert property (@(posedge clk) disable iff (rst)
    !wr_flags |=> $stable(flags_q));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the exec_core testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_exec_core \
  -f files.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- verification/exec_stim.txt
// op cond src_a src_b use_imm imm dest set_flags | executed value flags(c n v z) throttle
// op: 0 add 1 sub 2 and 3 xor 4 or 5 shl 6 shr 7 sar 8 movi, end marker op f
8 0 0 0 1 7fff 1 0  1 0000000000007fff 0 0
8 0 0 0 1 8000 2 0  1 ffffffffffff8000 4 0
8 0 0 0 1 0001 3 0  1 0000000000000001 0 0
8 0 0 0 1 ffff 4 0  1 ffffffffffffffff 4 0
0 0 4 3 0 0000 5 1  1 0000000000000000 9 0
6 0 4 0 1 0001 7 1  1 7fffffffffffffff 0 0
0 0 7 3 0 0000 8 1  1 8000000000000000 6 0
1 0 8 0 1 0001 b 1  1 7fffffffffffffff a 0
2 0 4 2 0 0000 c 1  1 ffffffffffff8000 4 0
3 0 2 0 1 7fff d 0  1 ffffffffffffffff 4 0
4 0 1 3 0 0000 e 1  1 0000000000007fff 0 0
5 0 1 0 1 0030 f 1  1 7fff000000000000 0 0
7 0 2 0 1 0044 c 1  1 fffffffffffff800 4 0
1 0 3 3 0 0000 0 1  1 0000000000000000 9 1
8 1 0 0 1 0011 1 0  0 0000000000000000 9 1
8 2 0 0 1 0011 6 0  1 0000000000000011 0 1
8 4 0 0 1 0011 6 0  1 0000000000000011 0 1
8 7 0 0 1 0011 6 0  1 0000000000000011 0 1
8 9 0 0 1 0011 6 0  1 0000000000000011 0 1
8 a 0 0 1 0011 1 0  0 0000000000000000 9 1
8 c 0 0 1 0011 6 0  1 0000000000000011 0 1
8 e 0 0 1 0011 1 0  0 0000000000000000 9 1
0 0 7 3 0 0000 8 1  1 8000000000000000 6 1
8 0 0 0 1 0011 6 0  1 0000000000000011 0 1
8 3 0 0 1 0011 6 0  1 0000000000000011 0 1
8 5 0 0 1 0011 6 0  1 0000000000000011 0 1
8 6 0 0 1 0011 6 0  1 0000000000000011 0 1
8 8 0 0 1 0011 6 0  1 0000000000000011 0 1
8 b 0 0 1 0011 6 0  1 0000000000000011 0 1
8 d 0 0 1 0011 1 0  0 0000000000000000 6 1
8 f 0 0 1 0011 1 0  0 0000000000000000 6 1
4 0 1 0 0 0000 9 0  1 0000000000007fff 0 1
f 0 0 0 0 0000 0 0  0 0000000000000000 0 0

//--- verification/tb_exec_core.sv
/*
  Testbench for the execution lane top level.
  Clock and reset, stimulus read from the stim file,
  random out_ready throttling, scoreboard with latency
  check, compare tasks and a watchdog.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core import exec_pkg::*; ();

  localparam int clk_period = 40;
  localparam int drive_dly  = 1;
  localparam int rec_w      = 12;  // words per stim record
  localparam int max_recs   = 64;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  exec_op_t  in_op;
  logic      out_valid;
  logic      out_ready;
  exec_res_t out_res;

  logic [63:0] stim_mem [rec_w*max_recs];
  int          n_recs = 0;
  int          n_recv = 0;
  int          cycle = 0;
  int          stall_cnt = 0;
  logic        throttle_on;
  exec_res_t   cur_exp;
  exec_res_t   exp_q [$];
  int          in_cycle_q [$];
  int          in_stall_q [$];
  exec_res_t   exp_r;
  int          t_in;
  int          s_in;

  exec_core dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) fail_stop($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    if (got !== exp) fail_stop($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) fail_stop($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_stop($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) fail_stop($sformatf("CHECK FAILED latency got %h expected %h", got, exp));
  endtask

  function automatic exec_op_t make_op(input int i);
    exec_op_t o;
    int       b;
    b = i * rec_w;
    o.op        = alu_op_t'(stim_mem[b][3:0]);
    o.cond      = cond_t'(stim_mem[b+1][3:0]);
    o.src_a     = stim_mem[b+2][3:0];
    o.src_b     = stim_mem[b+3][3:0];
    o.use_imm   = stim_mem[b+4][0];
    o.imm       = stim_mem[b+5][15:0];
    o.dest      = stim_mem[b+6][3:0];
    o.set_flags = stim_mem[b+7][0];
    return o;
  endfunction

  // write bits follow from executed and set_flags
  function automatic exec_res_t make_exp(input int i);
    exec_res_t e;
    int        b;
    b = i * rec_w;
    e.executed    = stim_mem[b+8][0];
    e.dest        = stim_mem[b+6][3:0];
    e.write_reg   = stim_mem[b+8][0];
    e.write_flags = stim_mem[b+8][0] & stim_mem[b+7][0];
    e.value       = stim_mem[b+9];
    e.flags       = stim_mem[b+10][3:0];
    return e;
  endfunction

  task automatic load_stim();
    $readmemh("verification/exec_stim.txt", stim_mem);
    while (n_recs < max_recs && stim_mem[n_recs*rec_w] != 64'hf) n_recs++;
    if (n_recs == 0 || n_recs == max_recs) fail_stop("stim file has no records or no end marker");
  endtask

  // holds the op until the DUT takes it
  task automatic send_op(input int i);
    logic acc;
    in_op       = make_op(i);
    cur_exp     = make_exp(i);
    throttle_on = stim_mem[i*rec_w+11][0];
    in_valid    = 1'b1;
    acc         = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = in_ready;
      @(posedge clk);
      #drive_dly;
    end
  endtask

  initial begin
    logic thr;
    void'($urandom(6));
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      thr = throttle_on;
      #drive_dly;
      out_ready = thr ? 1'($urandom) : 1'b1;
    end
  end

  // transfers seen at negedge happen on the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          fail_stop("result transfer with no operation outstanding");
        end else begin
          exp_r = exp_q.pop_front();
          t_in  = in_cycle_q.pop_front();
          s_in  = in_stall_q.pop_front();
          check_bit("out_res.executed", out_res.executed, exp_r.executed);
          check_reg_idx("out_res.dest", out_res.dest, exp_r.dest);
          check_bit("out_res.write_reg", out_res.write_reg, exp_r.write_reg);
          check_bit("out_res.write_flags", out_res.write_flags, exp_r.write_flags);
          check_data("out_res.value", out_res.value, exp_r.value);
          check_flags("out_res.flags", out_res.flags, exp_r.flags);
          if (s_in == stall_cnt) check_latency(cycle - t_in, 2);  // no stall in between
          n_recv++;
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(cur_exp);
        in_cycle_q.push_back(cycle);
        in_stall_q.push_back(stall_cnt);
      end
      if (!out_ready) stall_cnt++;
    end
  end

  initial begin
    wait (n_recs > 0);
    #((n_recs * 20 + 16) * clk_period);
    fail_stop("timeout, not all results arrived in time");
  end

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_op       = '0;
    throttle_on = 1'b0;
    cur_exp     = '0;
    load_stim();
    repeat (15) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b1);
    end
    @(posedge clk);
    #drive_dly rst = 1'b0;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    @(posedge clk);
    #drive_dly;
    for (int i = 0; i < n_recs; i++) send_op(i);
    in_valid = 1'b0;
    wait (n_recv == n_recs);
    repeat (4) @(negedge clk);  // catch any extra result
    if (out_valid !== 1'b0) begin
      fail_stop("an extra result is still waiting at the output after the last one");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
